/* design/wread_pkg.sv */
package wread_pkg;

   // lane count and datapath widths
   localparam int N_VECT     = 4;
   localparam int LANE_IDX_W = $clog2(N_VECT);
   localparam int DATA_W     = 32;
   localparam int EXT_ADDR_W = 32;
   localparam int MEM_ADDR_W = 5;
   localparam int CNT_W      = 6;
   localparam int OFFSET_W   = 16;
   localparam int CFG_ADDR_W = 3;

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [EXT_ADDR_W-1:0] ext_addr_t;
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [CNT_W-1:0]      cnt_t;
   typedef logic [OFFSET_W-1:0]   offset_t;
   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

   // register map
   localparam cfg_addr_t REG_EXT_ADDR  = 3'd0;
   localparam cfg_addr_t REG_OFFSET    = 3'd1;
   localparam cfg_addr_t REG_INT_ADDR  = 3'd2;
   localparam cfg_addr_t REG_FETCH_LEN = 3'd3;
   localparam cfg_addr_t REG_RD_START  = 3'd4;
   localparam cfg_addr_t REG_RD_ITER   = 3'd5;
   localparam cfg_addr_t REG_RD_PER    = 3'd6;
   localparam cfg_addr_t REG_RD_INCR   = 3'd7;

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_DONE} fetch_state_t;
   typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_RUN, RD_DONE} rd_state_t;

endpackage

/* design/wread_cfg_regs.sv */
`timescale 1ns/1ps

module wread_cfg_regs import wread_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_valid,
   input  cfg_addr_t              cfg_addr,
   input  word_t                  cfg_wdata,
   input  logic                   cfg_we,
   input  logic                   run,
   output logic                   start,
   output ext_addr_t [N_VECT-1:0] lane_base,
   output mem_addr_t              int_addr,
   output cnt_t                   fetch_len,
   output cnt_t                   rd_iter,
   output cnt_t                   rd_per,
   output mem_addr_t              rd_start,
   output mem_addr_t              rd_incr
);

   // cpu-visible registers
   ext_addr_t cfg_ext_addr;
   offset_t   cfg_offset;
   mem_addr_t cfg_int_addr;
   cnt_t      cfg_fetch_len;
   mem_addr_t cfg_rd_start;
   cnt_t      cfg_rd_iter;
   cnt_t      cfg_rd_per;
   mem_addr_t cfg_rd_incr;

   ext_addr_t [N_VECT-1:0] base_calc;
   logic                   wr_en;

   assign wr_en = cfg_valid && cfg_we;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_ext_addr  <= '0;
         cfg_offset    <= '0;
         cfg_int_addr  <= '0;
         cfg_fetch_len <= '0;
         cfg_rd_start  <= '0;
         cfg_rd_iter   <= '0;
         cfg_rd_per    <= '0;
         cfg_rd_incr   <= '0;
      end else if (wr_en) begin
         case (cfg_addr)
            REG_EXT_ADDR:  cfg_ext_addr  <= cfg_wdata[EXT_ADDR_W-1:0];
            REG_OFFSET:    cfg_offset    <= cfg_wdata[OFFSET_W-1:0];
            REG_INT_ADDR:  cfg_int_addr  <= cfg_wdata[MEM_ADDR_W-1:0];
            REG_FETCH_LEN: cfg_fetch_len <= cfg_wdata[CNT_W-1:0];
            REG_RD_START:  cfg_rd_start  <= cfg_wdata[MEM_ADDR_W-1:0];
            REG_RD_ITER:   cfg_rd_iter   <= cfg_wdata[CNT_W-1:0];
            REG_RD_PER:    cfg_rd_per    <= cfg_wdata[CNT_W-1:0];
            REG_RD_INCR:   cfg_rd_incr   <= cfg_wdata[MEM_ADDR_W-1:0];
         endcase
      end
   end

   // lane l starts at ext_addr + l * offset, built as a chain of adds
   always_comb begin
      ext_addr_t acc;
      acc = cfg_ext_addr;
      for (int l = 0; l < N_VECT; l++) begin
         base_calc[l] = acc;
         acc = acc + ext_addr_t'(cfg_offset);
      end
   end

   // shadow copy taken on run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_base <= '0;
         int_addr  <= '0;
         fetch_len <= '0;
         rd_start  <= '0;
         rd_iter   <= '0;
         rd_per    <= '0;
         rd_incr   <= '0;
      end else if (run) begin
         lane_base <= base_calc;
         int_addr  <= cfg_int_addr;
         fetch_len <= cfg_fetch_len;
         rd_start  <= cfg_rd_start;
         rd_iter   <= cfg_rd_iter;
         rd_per    <= cfg_rd_per;
         rd_incr   <= cfg_rd_incr;
      end
   end

   // engines start once the shadows hold the new values
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start <= 1'b0;
      end else begin
         start <= run;
      end
   end

endmodule

/* design/ext_fetch.sv */
`timescale 1ns/1ps

module ext_fetch import wread_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      start,
   input  ext_addr_t lane_base,
   input  mem_addr_t int_addr,
   input  cnt_t      fetch_len,
   output logic      req_valid,
   output ext_addr_t req_addr,
   input  logic      req_ready,
   input  word_t     rdata,
   output logic      mem_we,
   output mem_addr_t mem_waddr,
   output word_t     mem_wdata,
   output logic      fetch_done
);

   fetch_state_t state;
   cnt_t         word_cnt;
   cnt_t         word_cnt_next;
   ext_addr_t    addr_q;
   logic         beat;

   assign word_cnt_next = word_cnt + 1'b1;

   // a word arrives in the ready cycle of our request
   assign beat = (state == FETCH_REQ) && req_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= FETCH_IDLE;
         word_cnt <= '0;
         addr_q   <= '0;
      end else if (start) begin
         // restart from any state
         word_cnt <= '0;
         addr_q   <= lane_base;
         state    <= (fetch_len == '0) ? FETCH_DONE : FETCH_REQ;
      end else if (beat) begin
         word_cnt <= word_cnt_next;
         addr_q   <= addr_q + 1'b1;
         if (word_cnt_next == fetch_len) begin
            state <= FETCH_DONE;
         end
      end
   end

   // request held until ready since addr_q only moves on a beat
   assign req_valid = (state == FETCH_REQ);
   assign req_addr  = addr_q;

   // lane memory write, wraps inside the 32-word array
   assign mem_we    = beat;
   assign mem_waddr = int_addr + word_cnt[MEM_ADDR_W-1:0];
   assign mem_wdata = rdata;

   assign fetch_done = (state == FETCH_DONE);

   a_req_addr_stable : assert property (
      @(posedge clk) disable iff (rst)
      req_valid && !req_ready && !start |=> $stable(req_addr)
   ) else $error("request address changed while waiting for ready");

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import wread_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [N_VECT-1:0]      req_valid,
   input  ext_addr_t [N_VECT-1:0] req_addr,
   output logic [N_VECT-1:0]      req_ready,
   output logic                   databus_valid,
   output ext_addr_t              databus_addr,
   input  logic                   databus_ready
);

   logic [LANE_IDX_W-1:0] grant_q;
   logic [LANE_IDX_W-1:0] pick;
   logic [LANE_IDX_W-1:0] sel;
   logic                  locked;

   // lowest valid index wins
   always_comb begin
      pick = '0;
      for (int i = N_VECT - 1; i >= 0; i--) begin
         if (req_valid[i]) begin
            pick = LANE_IDX_W'(i);
         end
      end
   end

   assign sel           = locked ? grant_q : pick;
   assign databus_valid = req_valid[sel];
   assign databus_addr  = req_addr[sel];

   always_comb begin
      req_ready = '0;
      if (databus_valid && databus_ready) begin
         req_ready[sel] = 1'b1;
      end
   end

   // keep the grant while the slave stalls
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         locked  <= 1'b0;
         grant_q <= '0;
      end else begin
         locked  <= databus_valid && !databus_ready;
         grant_q <= sel;
      end
   end

   a_ready_onehot : assert property (
      @(posedge clk) disable iff (rst) $onehot0(req_ready)
   ) else $error("more than one lane got ready");

endmodule

/* design/weight_mem.sv */
`timescale 1ns/1ps

module weight_mem import wread_pkg::*; (
   input  logic      clk,
   input  logic      mem_we,
   input  mem_addr_t mem_waddr,
   input  word_t     mem_wdata,
   input  logic      rd_en,
   input  mem_addr_t rd_addr,
   output word_t     rd_data
);

   word_t     mem [2**MEM_ADDR_W];

   // write side input registers
   logic      we_q;
   mem_addr_t waddr_q;
   word_t     wdata_q;

   word_t     rd_q;

   always_ff @(posedge clk) begin
      we_q    <= mem_we;
      waddr_q <= mem_waddr;
      wdata_q <= mem_wdata;
      if (we_q) begin
         mem[waddr_q] <= wdata_q;
      end
   end

   // two output stages, data shows two cycles after rd_en
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_q <= mem[rd_addr];
      end
      rd_data <= rd_q;
   end

endmodule

/* design/int_addrgen.sv */
`timescale 1ns/1ps

module int_addrgen import wread_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  logic [N_VECT-1:0] fetch_done,
   input  mem_addr_t         rd_start,
   input  mem_addr_t         rd_incr,
   input  cnt_t              rd_iter,
   input  cnt_t              rd_per,
   output logic              rd_en,
   output mem_addr_t         rd_addr,
   output logic              weights_valid,
   output logic              done
);

   rd_state_t state;
   cnt_t      iter_cnt;
   cnt_t      per_cnt;
   cnt_t      iter_next;
   cnt_t      per_next;
   mem_addr_t base_q;
   logic      all_done;
   logic      empty_pattern;
   logic      last_per;
   logic      last_read;
   logic      vld_q1;
   logic      vld_q2;
   logic      done_q;

   assign all_done      = &fetch_done;
   assign empty_pattern = (rd_iter == '0) || (rd_per == '0);
   assign per_next      = per_cnt + 1'b1;
   assign iter_next     = iter_cnt + 1'b1;
   assign last_per      = (per_next == rd_per);
   assign last_read     = last_per && (iter_next == rd_iter);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= RD_IDLE;
         iter_cnt <= '0;
         per_cnt  <= '0;
         base_q   <= '0;
      end else if (start) begin
         state    <= RD_WAIT;
         iter_cnt <= '0;
         per_cnt  <= '0;
         base_q   <= rd_start;
      end else begin
         case (state)
            RD_WAIT: begin
               if (all_done) begin
                  state <= empty_pattern ? RD_DONE : RD_RUN;
               end
            end
            RD_RUN: begin
               // base moves by rd_incr at the end of each period
               if (last_per) begin
                  per_cnt  <= '0;
                  iter_cnt <= iter_next;
                  base_q   <= base_q + rd_incr;
               end else begin
                  per_cnt <= per_next;
               end
               if (last_read) begin
                  state <= RD_DONE;
               end
            end
            default: ;
         endcase
      end
   end

   assign rd_en   = (state == RD_RUN);
   assign rd_addr = base_q + per_cnt[MEM_ADDR_W-1:0];

   // valid follows the read and output registers of the memories
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_q1 <= 1'b0;
         vld_q2 <= 1'b0;
         done_q <= 1'b0;
      end else if (start) begin
         vld_q1 <= 1'b0;
         vld_q2 <= 1'b0;
         done_q <= 1'b0;
      end else begin
         vld_q1 <= rd_en;
         vld_q2 <= vld_q1;
         if (state == RD_WAIT && all_done && empty_pattern) begin
            done_q <= 1'b1;
         end else if (state == RD_DONE && !vld_q1) begin
            // last valid is on the output now
            done_q <= 1'b1;
         end
      end
   end

   assign weights_valid = vld_q2;
   assign done          = done_q;

   a_read_after_fetch : assert property (
      @(posedge clk) disable iff (rst) rd_en |-> all_done
   ) else $error("lane memory read before every fetch finished");

endmodule

/* design/wread_top.sv */
`timescale 1ns/1ps

module wread_top import wread_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_valid,
   input  cfg_addr_t              cfg_addr,
   input  word_t                  cfg_wdata,
   input  logic                   cfg_we,
   input  logic                   run,
   output logic                   databus_valid,
   output ext_addr_t              databus_addr,
   input  logic                   databus_ready,
   input  word_t                  databus_rdata,
   output word_t [N_VECT-1:0]     weights,
   output logic                   weights_valid,
   output logic                   done
);

   // shadowed configuration
   logic                   start;
   ext_addr_t [N_VECT-1:0] lane_base;
   mem_addr_t              int_addr;
   mem_addr_t              rd_start;
   mem_addr_t              rd_incr;
   cnt_t                   fetch_len;
   cnt_t                   rd_iter;
   cnt_t                   rd_per;

   // lane requests towards the arbiter
   logic [N_VECT-1:0]      req_valid;
   ext_addr_t [N_VECT-1:0] req_addr;
   logic [N_VECT-1:0]      req_ready;
   logic [N_VECT-1:0]      fetch_done;

   // shared read port of all lane memories
   logic                   rd_en;
   mem_addr_t              rd_addr;

   wread_cfg_regs cfg_regs_i (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_we    (cfg_we),
      .run       (run),
      .start     (start),
      .lane_base (lane_base),
      .int_addr  (int_addr),
      .fetch_len (fetch_len),
      .rd_iter   (rd_iter),
      .rd_per    (rd_per),
      .rd_start  (rd_start),
      .rd_incr   (rd_incr)
   );

   for (genvar l = 0; l < N_VECT; l++) begin : g_lane
      logic      mem_we;
      mem_addr_t mem_waddr;
      word_t     mem_wdata;

      ext_fetch fetch_i (
         .clk        (clk),
         .rst        (rst),
         .start      (start),
         .lane_base  (lane_base[l]),
         .int_addr   (int_addr),
         .fetch_len  (fetch_len),
         .req_valid  (req_valid[l]),
         .req_addr   (req_addr[l]),
         .req_ready  (req_ready[l]),
         .rdata      (databus_rdata),
         .mem_we     (mem_we),
         .mem_waddr  (mem_waddr),
         .mem_wdata  (mem_wdata),
         .fetch_done (fetch_done[l])
      );

      weight_mem mem_i (
         .clk       (clk),
         .mem_we    (mem_we),
         .mem_waddr (mem_waddr),
         .mem_wdata (mem_wdata),
         .rd_en     (rd_en),
         .rd_addr   (rd_addr),
         .rd_data   (weights[l])
      );
   end

   bus_arbiter arbiter_i (
      .clk           (clk),
      .rst           (rst),
      .req_valid     (req_valid),
      .req_addr      (req_addr),
      .req_ready     (req_ready),
      .databus_valid (databus_valid),
      .databus_addr  (databus_addr),
      .databus_ready (databus_ready)
   );

   int_addrgen addrgen_i (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .fetch_done    (fetch_done),
      .rd_start      (rd_start),
      .rd_incr       (rd_incr),
      .rd_iter       (rd_iter),
      .rd_per        (rd_per),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .weights_valid (weights_valid),
      .done          (done)
   );

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic rst
);

   localparam int HALF_PERIOD = 10;
   localparam int RST_CYCLES  = 3;

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

   // reset covers the first three clock periods
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

/* verification/wread_tb.sv */
`timescale 1ns/1ps

module wread_tb import wread_pkg::*; ();

   localparam int MAX_TESTS   = 8;
   localparam int MAX_ROWS    = 64;
   localparam int N_REGS      = 8;
   localparam int HOLD_CYCLES = 3;

   logic               clk;
   logic               rst;
   logic               cfg_valid;
   cfg_addr_t          cfg_addr;
   word_t              cfg_wdata;
   logic               cfg_we;
   logic               run;
   logic               databus_valid;
   ext_addr_t          databus_addr;
   logic               databus_ready = 1'b0;
   word_t              databus_rdata = '0;
   word_t [N_VECT-1:0] weights;
   logic               weights_valid;
   logic               done;

   // tables filled from the stim file
   word_t cfg_tab [MAX_TESTS][N_REGS];
   int    max_dly_tab [MAX_TESTS];
   int    row_first [MAX_TESTS];
   int    row_count [MAX_TESTS];
   word_t exp_tab [MAX_ROWS][N_VECT];
   int    n_tests = 0;
   int    n_rows = 0;

   int     data_errors = 0;
   int     bus_errors = 0;
   int     ctl_errors = 0;
   int     rows_seen = 0;
   int     cur_test = 0;
   int     max_delay = 0;
   int     cycles = 0;
   int     limit = 0;
   integer seed = 32'h565f;

   // external memory model state
   int        delay = 0;
   logic      waiting = 1'b0;
   logic      held = 1'b0;
   ext_addr_t held_addr = '0;

   clk_gen clk_gen_i (
      .clk (clk),
      .rst (rst)
   );

   wread_top wread_top_i (
      .clk           (clk),
      .rst           (rst),
      .cfg_valid     (cfg_valid),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_we        (cfg_we),
      .run           (run),
      .databus_valid (databus_valid),
      .databus_addr  (databus_addr),
      .databus_ready (databus_ready),
      .databus_rdata (databus_rdata),
      .weights       (weights),
      .weights_valid (weights_valid),
      .done          (done)
   );

   // word that external memory returns for an address
   function automatic word_t model_word(input ext_addr_t a);
      return {a[15:0], ~a[15:0]};
   endfunction

   // weight of lane l for read n of test t
   function automatic word_t rule_weight(input int t, input int n, input int l);
      int        per;
      int        ai;
      mem_addr_t a;
      mem_addr_t k;
      ext_addr_t base;
      per  = int'(cfg_tab[t][REG_RD_PER][CNT_W-1:0]);
      ai   = int'(cfg_tab[t][REG_RD_START][MEM_ADDR_W-1:0])
           + (n / per) * int'(cfg_tab[t][REG_RD_INCR][MEM_ADDR_W-1:0]) + n % per;
      a    = mem_addr_t'(ai);
      k    = a - mem_addr_t'(cfg_tab[t][REG_INT_ADDR]);
      base = cfg_tab[t][REG_EXT_ADDR]
           + ext_addr_t'(l) * ext_addr_t'(cfg_tab[t][REG_OFFSET][OFFSET_W-1:0]);
      return model_word(base + ext_addr_t'(k));
   endfunction

   task automatic load_stim();
      int    fd;
      int    cnt;
      int    dly;
      string line;
      word_t v [N_REGS];
      word_t e [N_VECT];
      fd = $fopen("verification/wread_stim.txt", "r");
      if (fd == 0) begin
         ctl_errors++;
         $display("could not open verification/wread_stim.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            case (line[0])
               "C": begin
                  cnt = $sscanf(line, "C %h %h %h %h %h %h %h %h %d",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], dly);
                  if (cnt != 9) begin
                     ctl_errors++;
                     $display("badly formed configuration row: %s", line);
                  end
                  for (int r = 0; r < N_REGS; r++) begin
                     cfg_tab[n_tests][r] = v[r];
                  end
                  max_dly_tab[n_tests] = dly;
                  row_first[n_tests]   = n_rows;
                  row_count[n_tests]   = 0;
               end
               "E": begin
                  cnt = $sscanf(line, "E %h %h %h %h", e[0], e[1], e[2], e[3]);
                  if (cnt != N_VECT) begin
                     ctl_errors++;
                     $display("badly formed expected row: %s", line);
                  end
                  for (int l = 0; l < N_VECT; l++) begin
                     exp_tab[n_rows][l] = e[l];
                  end
                  n_rows++;
                  row_count[n_tests]++;
               end
               "X": n_tests++;
               default: ;
            endcase
         end
         $fclose(fd);
      end
   endtask

   task automatic check_idle();
      repeat (2) begin
         @(negedge clk);
         assert (!databus_valid && !weights_valid && !done) else begin
            ctl_errors++;
            $display("Mismatch at %0t ns: outputs not idle after reset (%b %b %b)",
                     $time, databus_valid, weights_valid, done);
         end
      end
   endtask

   task automatic run_test(input int t);
      int n_expect;
      n_expect = int'(cfg_tab[t][REG_RD_ITER][CNT_W-1:0])
               * int'(cfg_tab[t][REG_RD_PER][CNT_W-1:0]);
      if (n_expect != row_count[t]) begin
         ctl_errors++;
         $display("test %0d has %0d expected rows but its read pattern makes %0d",
                  t, row_count[t], n_expect);
      end
      cur_test  = t;
      max_delay = max_dly_tab[t];
      for (int r = 0; r < N_REGS; r++) begin
         @(negedge clk);
         cfg_valid = 1'b1;
         cfg_we    = 1'b1;
         cfg_addr  = cfg_addr_t'(r);
         cfg_wdata = cfg_tab[t][r];
      end
      @(negedge clk);
      cfg_valid = 1'b0;
      cfg_we    = 1'b0;
      run       = 1'b1;
      @(negedge clk);
      run = 1'b0;
      @(negedge clk);
      // start has cleared done by now
      assert (done == 1'b0) else begin
         ctl_errors++;
         $display("Mismatch at %0t ns: done still high after run of test %0d", $time, t);
      end
      while (done == 1'b0) begin
         @(negedge clk);
      end
      assert (rows_seen == row_first[t] + row_count[t]) else begin
         ctl_errors++;
         $display("Mismatch at %0t ns: test %0d gave %0d weight rows, expected %0d",
                  $time, t, rows_seen - row_first[t], row_count[t]);
      end
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         assert (done == 1'b1) else begin
            ctl_errors++;
            $display("Mismatch at %0t ns: done fell before the next run", $time);
         end
      end
   endtask

   task automatic report_and_finish(input logic timed_out);
      int total;
      total = data_errors + bus_errors + ctl_errors;
      $display("errors: %0d weight data, %0d databus, %0d control; %0d weight rows seen",
               data_errors, bus_errors, ctl_errors, rows_seen);
      if (!timed_out && total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   initial begin
      cfg_valid = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      cfg_we    = 1'b0;
      run       = 1'b0;
      load_stim();
      if (n_tests == 0) begin
         ctl_errors++;
         $display("stimulus file holds no complete test");
      end
      for (int t = 0; t < n_tests; t++) begin
         limit = limit
               + int'(cfg_tab[t][REG_FETCH_LEN][CNT_W-1:0]) * N_VECT * (max_dly_tab[t] + 2)
               + int'(cfg_tab[t][REG_RD_ITER][CNT_W-1:0])
               * int'(cfg_tab[t][REG_RD_PER][CNT_W-1:0]) + 20;
      end
      @(negedge rst);
      check_idle();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      report_and_finish(1'b0);
   end

   // memory answers each request after 0 to max_delay idle cycles
   always @(negedge clk) begin
      if (rst) begin
         databus_ready = 1'b0;
         waiting       = 1'b0;
         held          = 1'b0;
      end else begin
         if (held) begin
            assert (databus_valid && databus_addr == held_addr) else begin
               bus_errors++;
               $display("Mismatch at %0t ns: waiting request changed from %h to %h",
                        $time, held_addr, databus_addr);
            end
         end
         if (databus_valid) begin
            if (!waiting) begin
               delay   = ($random(seed) & 32'h7fff_ffff) % (max_delay + 1);
               waiting = 1'b1;
            end
            if (delay == 0) begin
               databus_ready = 1'b1;
               databus_rdata = model_word(databus_addr);
               waiting       = 1'b0;
            end else begin
               databus_ready = 1'b0;
               delay         = delay - 1;
            end
         end else begin
            databus_ready = 1'b0;
            waiting       = 1'b0;
         end
         held      = databus_valid && !databus_ready;
         held_addr = databus_addr;
      end
   end

   // weight rows against the stim file and the memory rule
   always @(negedge clk) begin
      if (!rst && weights_valid) begin
         if (rows_seen >= row_first[cur_test] + row_count[cur_test]) begin
            data_errors++;
            $display("weights_valid rose more often than the read pattern allows at %0t ns",
                     $time);
         end else begin
            for (int l = 0; l < N_VECT; l++) begin
               assert (exp_tab[rows_seen][l]
                       == rule_weight(cur_test, rows_seen - row_first[cur_test], l)) else begin
                  data_errors++;
                  $display("Mismatch at %0t ns: stim row %0d lane %0d disagrees with rule",
                           $time, rows_seen, l);
               end
               assert (weights[l] == exp_tab[rows_seen][l]) else begin
                  data_errors++;
                  $display("Mismatch at %0t ns: row %0d lane %0d got %h expected %h",
                           $time, rows_seen, l, weights[l], exp_tab[rows_seen][l]);
               end
            end
         end
         rows_seen++;
      end
      if (!rst) begin
         assert (!(weights_valid && done)) else begin
            data_errors++;
            $display("Mismatch at %0t ns: done high together with weights_valid", $time);
         end
      end
   end

   always @(posedge clk) begin
      if (!rst && limit > 0) begin
         cycles = cycles + 1;
         if (cycles >= limit) begin
            $display("timeout: done never rose");
            report_and_finish(1'b1);
         end
      end
   end

endmodule

/* build.f */
design/wread_pkg.sv
design/wread_cfg_regs.sv
design/ext_fetch.sv
design/bus_arbiter.sv
design/weight_mem.sv
design/int_addrgen.sv
design/wread_top.sv
verification/clk_gen.sv
verification/wread_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the weight reader testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module wread_tb \
   && ./obj_dir/Vwread_tb | tee sim.log \
   && grep -q "^TEST OK$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

exit 0

/* verification/wread_stim.txt */
# C ext_addr offset int_addr fetch_len rd_start rd_iter rd_per rd_incr (hex), max ready delay (dec)
# E expected weights, lane 0 first (hex); X ends a test
C 00001000 0040 00 03 00 01 03 00 0
E 1000EFFF 1040EFBF 1080EF7F 10C0EF3F
E 1001EFFE 1041EFBE 1081EF7E 10C1EF3E
E 1002EFFD 1042EFBD 1082EF7D 10C2EF3D
X
C 00002000 0100 1E 04 1F 02 02 1F 3
E 2001DFFE 2101DEFE 2201DDFE 2301DCFE
E 2002DFFD 2102DEFD 2202DDFD 2302DCFD
E 2000DFFF 2100DEFF 2200DDFF 2300DCFF
E 2001DFFE 2101DEFE 2201DDFE 2301DCFE
X
C 00003000 0010 05 02 00 00 03 01 2
X
